// ==== hw/cpuPkg.sv ====
package cpuPkg;

    ////////////////////////////////////////////////////////////
    // Widths and fixed registers
    ////////////////////////////////////////////////////////////

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;

    // Overflow status code goes here
    localparam logic [regAddrWidth-1:0] statusReg = 5'd30;
    // Return address of jal
    localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        opRType = 5'd0,
        opJ     = 5'd1,
        opBne   = 5'd2,
        opJal   = 5'd3,
        opJr    = 5'd4,
        opAddi  = 5'd5,
        opBlt   = 5'd6,
        opSw    = 5'd7,
        opLw    = 5'd8
    } opcodeE;

    typedef enum logic [4:0] {
        aluAdd = 5'd0,
        aluSub = 5'd1,
        aluAnd = 5'd2,
        aluOr  = 5'd3,
        aluSll = 5'd4,
        aluSra = 5'd5
    } aluOpE;

    typedef enum logic [1:0] {
        addOvf  = 2'd1,
        addiOvf = 2'd2,
        subOvf  = 2'd3
    } statusCodeE;

    // All-zero word is the bubble, add r0 r0 r0
    typedef struct packed {
        opcodeE                  opcode;
        logic [regAddrWidth-1:0] rd;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [4:0]              shamt;
        aluOpE                   aluOp;
        logic [1:0]              pad;
    } instrT;

    ////////////////////////////////////////////////////////////
    // Pipeline bundles
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                    en;
        logic [regAddrWidth-1:0] idx;
        logic [dataWidth-1:0]    data;
    } wbT;

    // rtVal holds rd for instructions that read rd
    typedef struct packed {
        instrT                   instr;
        logic [dataWidth-1:0]    pcPlus1;
        logic [dataWidth-1:0]    rsVal;
        logic [dataWidth-1:0]    rtVal;
        logic [regAddrWidth-1:0] rtIdx;
    } dxT;

    typedef struct packed {
        instrT                instr;
        logic [dataWidth-1:0] result;
        logic [dataWidth-1:0] storeVal;
    } xmT;

    typedef struct packed {
        instrT                instr;
        logic [dataWidth-1:0] result;
        logic [dataWidth-1:0] loadData;
    } mwT;

    // Destination register, jal always links through r31
    function automatic logic [regAddrWidth-1:0] destReg(instrT instr);
        return (instr.opcode == opJal) ? linkReg : instr.rd;
    endfunction

    // True only for a real write, r0 never counts
    function automatic logic writesReg(instrT instr);
        logic kind;
        kind = instr.opcode inside {opRType, opAddi, opLw, opJal};
        return kind && (destReg(instr) != '0);
    endfunction

endpackage

// ==== hw/fetchStage.sv ====
module fetchStage import cpuPkg::*; #(
    parameter int imemAddrWidth = 12
) (
    input  logic                     clock,
    input  logic                     rst,
    input  logic                     loadUseStall,
    input  logic                     redirectValid,
    input  logic [dataWidth-1:0]     redirectPc,
    output logic [imemAddrWidth-1:0] imemAddr,
    input  logic [dataWidth-1:0]     imemData,
    output instrT                    fdInstr,
    output logic [dataWidth-1:0]     fdPcPlus1
);

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcPlus1;

    assign pcPlus1 = pc + 1'b1;
    // Only the low PC bits reach instruction memory
    assign imemAddr = pc[imemAddrWidth-1:0];

    // Redirect wins over a stall
    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
            fdInstr <= '0;
            fdPcPlus1 <= '0;
        end else if (redirectValid) begin
            pc <= redirectPc;
            // Squash the word fetched behind the jump
            fdInstr <= '0;
            fdPcPlus1 <= pcPlus1;
        end else if (!loadUseStall) begin
            pc <= pcPlus1;
            fdInstr <= imemData;
            fdPcPlus1 <= pcPlus1;
        end
    end

    // PC steps by one unless stalled, absent a redirect
    pcStepCheck: assert property (@(posedge clock) disable iff (rst)
        !redirectValid |=> pc == $past(pc) + dataWidth'(!$past(loadUseStall)));

endmodule

// ==== hw/regFile.sv ====
module regFile import cpuPkg::*; (
    input  logic                    clock,
    input  logic                    rst,
    input  logic [regAddrWidth-1:0] readIdxA,
    input  logic [regAddrWidth-1:0] readIdxB,
    output logic [dataWidth-1:0]    readDataA,
    output logic [dataWidth-1:0]    readDataB,
    input  wbT                      wb
);

    // r0 is not stored
    logic [dataWidth-1:0] regs [1:31];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.idx != '0) begin
            regs[wb.idx] <= wb.data;
        end
    end

    // Same-cycle write shows up on the read side
    assign readDataA = (readIdxA == '0) ? '0 :
                       (wb.en && wb.idx == readIdxA) ? wb.data : regs[readIdxA];
    assign readDataB = (readIdxB == '0) ? '0 :
                       (wb.en && wb.idx == readIdxB) ? wb.data : regs[readIdxB];

    // r0 reads zero on both ports in every cycle
    zeroRegCheck: assert property (@(posedge clock) disable iff (rst)
        (readIdxA != '0 || readDataA == '0) && (readIdxB != '0 || readDataB == '0));

endmodule

// ==== hw/decodeStage.sv ====
module decodeStage import cpuPkg::*; (
    input  logic                    clock,
    input  logic                    rst,
    input  instrT                   fdInstr,
    input  logic [dataWidth-1:0]    fdPcPlus1,
    output logic [regAddrWidth-1:0] readIdxA,
    output logic [regAddrWidth-1:0] readIdxB,
    input  logic [dataWidth-1:0]    readDataA,
    input  logic [dataWidth-1:0]    readDataB,
    input  logic                    redirectValid,
    output logic                    loadUseStall,
    output dxT                      dx
);

    logic usesRd;
    logic isStore;
    logic dxIsLoad;
    logic rsHazard;
    logic rtHazard;
    dxT   dxNext;

    ////////////////////////////////////////////////////////////
    // Register read select
    ////////////////////////////////////////////////////////////

    // Branches, jr and sw read rd in place of rt
    assign usesRd = fdInstr.opcode inside {opBne, opJr, opBlt, opSw};
    assign isStore = fdInstr.opcode == opSw;

    assign readIdxA = fdInstr.rs;
    assign readIdxB = usesRd ? fdInstr.rd : fdInstr.rt;

    ////////////////////////////////////////////////////////////
    // Load-use hazard
    ////////////////////////////////////////////////////////////

    assign dxIsLoad = dx.instr.opcode == opLw;
    assign rsHazard = dx.instr.rd == readIdxA;
    // Store data is patched later from MW, so sw needs no bubble for it
    assign rtHazard = (dx.instr.rd == readIdxB) && !isStore;
    assign loadUseStall = dxIsLoad && (rsHazard || rtHazard);

    ////////////////////////////////////////////////////////////
    // DX latch
    ////////////////////////////////////////////////////////////

    always_comb begin
        dxNext.instr = fdInstr;
        dxNext.pcPlus1 = fdPcPlus1;
        dxNext.rsVal = readDataA;
        dxNext.rtVal = readDataB;
        dxNext.rtIdx = readIdxB;
        // Bubble on a stall or behind a taken jump
        if (loadUseStall || redirectValid) begin
            dxNext.instr = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            dx <= '0;
        end else begin
            dx <= dxNext;
        end
    end

endmodule

// ==== hw/aluUnit.sv ====
module aluUnit import cpuPkg::*; (
    input  logic [dataWidth-1:0] operandA,
    input  logic [dataWidth-1:0] operandB,
    input  aluOpE                aluOp,
    input  logic [4:0]           shamt,
    output logic [dataWidth-1:0] result,
    output logic                 notEqual,
    output logic                 lessThan,
    output logic                 overflow
);

    logic [dataWidth-1:0] sum;
    logic [dataWidth-1:0] diff;
    logic                 sumOvf;
    logic                 diffOvf;

    assign sum = operandA + operandB;
    assign diff = operandA - operandB;

    // Signed overflow from the sign bits
    assign sumOvf = (operandA[dataWidth-1] == operandB[dataWidth-1])
                    && (sum[dataWidth-1] != operandA[dataWidth-1]);
    assign diffOvf = (operandA[dataWidth-1] != operandB[dataWidth-1])
                     && (diff[dataWidth-1] != operandA[dataWidth-1]);

    // Compare flags come off the subtractor
    assign notEqual = diff != '0;
    assign lessThan = diff[dataWidth-1] ^ diffOvf;

    always_comb begin
        case (aluOp)
            aluAdd: result = sum;
            aluSub: result = diff;
            aluAnd: result = operandA & operandB;
            aluOr: result = operandA | operandB;
            aluSll: result = operandA << shamt;
            aluSra: result = $signed(operandA) >>> shamt;
            default: result = sum;
        endcase
    end

    assign overflow = (aluOp == aluAdd) ? sumOvf :
                      (aluOp == aluSub) ? diffOvf : 1'b0;

endmodule

// ==== hw/executeStage.sv ====
module executeStage import cpuPkg::*; (
    input  logic                 clock,
    input  logic                 rst,
    input  dxT                   dx,
    input  logic [dataWidth-1:0] xmForwardData,
    input  wbT                   wb,
    output logic                 redirectValid,
    output logic [dataWidth-1:0] redirectPc,
    output xmT                   xm
);

    logic [dataWidth-1:0] instrWord;
    opcodeE               opcode;
    logic [dataWidth-1:0] immExt;
    logic [dataWidth-1:0] target;
    logic                 xmWrites;
    logic [dataWidth-1:0] fwdA;
    logic [dataWidth-1:0] fwdB;
    logic                 isImm;
    logic                 isBranch;
    logic                 isBlt;
    logic [dataWidth-1:0] secondOp;
    logic [dataWidth-1:0] aluA;
    logic [dataWidth-1:0] aluB;
    aluOpE                aluOp;
    logic [dataWidth-1:0] aluResult;
    logic                 notEqual;
    logic                 lessThan;
    logic                 overflow;
    logic                 isJump;
    logic                 isJr;
    logic                 branchTaken;
    logic                 addOverflow;
    logic                 addiOverflow;
    logic                 subOverflow;
    logic                 anyOverflow;
    statusCodeE           statusCode;
    instrT                ovfInstr;
    xmT                   xmNext;

    assign instrWord = dx.instr;
    assign opcode = dx.instr.opcode;
    assign immExt = {{(dataWidth-17){instrWord[16]}}, instrWord[16:0]};
    assign target = {{(dataWidth-27){1'b0}}, instrWord[26:0]};

    ////////////////////////////////////////////////////////////
    // Operand forwarding
    ////////////////////////////////////////////////////////////

    // XM beats MW beats the latched register value
    assign xmWrites = writesReg(xm.instr);

    assign fwdA = (xmWrites && destReg(xm.instr) == dx.instr.rs) ? xmForwardData :
                  (wb.en && wb.idx == dx.instr.rs) ? wb.data : dx.rsVal;
    assign fwdB = (xmWrites && destReg(xm.instr) == dx.rtIdx) ? xmForwardData :
                  (wb.en && wb.idx == dx.rtIdx) ? wb.data : dx.rtVal;

    // addi, lw and sw take the immediate
    assign isImm = opcode inside {opAddi, opLw, opSw};
    assign isBranch = opcode inside {opBne, opBlt};
    assign isBlt = opcode == opBlt;
    assign secondOp = isImm ? immExt : fwdB;

    // blt tests rd < rs, so rd goes on side A
    assign aluA = isBlt ? secondOp : fwdA;
    assign aluB = isBlt ? fwdA : secondOp;
    assign aluOp = isImm ? aluAdd : isBranch ? aluSub : dx.instr.aluOp;

    aluUnit alu (
        .operandA (aluA),
        .operandB (aluB),
        .aluOp    (aluOp),
        .shamt    (dx.instr.shamt),
        .result   (aluResult),
        .notEqual (notEqual),
        .lessThan (lessThan),
        .overflow (overflow)
    );

    ////////////////////////////////////////////////////////////
    // Control flow
    ////////////////////////////////////////////////////////////

    assign isJump = opcode inside {opJ, opJal};
    assign isJr = opcode == opJr;
    assign branchTaken = (opcode == opBne && notEqual) || (isBlt && lessThan);

    assign redirectValid = isJump || isJr || branchTaken;
    // jr target is the forwarded rd value
    assign redirectPc = isJr ? fwdB : isJump ? target : dx.pcPlus1 + immExt;

    ////////////////////////////////////////////////////////////
    // Overflow rewrite and XM latch
    ////////////////////////////////////////////////////////////

    assign addOverflow = overflow && opcode == opRType && dx.instr.aluOp == aluAdd;
    assign subOverflow = overflow && opcode == opRType && dx.instr.aluOp == aluSub;
    assign addiOverflow = overflow && opcode == opAddi;
    assign anyOverflow = addOverflow || subOverflow || addiOverflow;

    always_comb begin
        if (subOverflow) begin
            statusCode = subOvf;
        end else if (addiOverflow) begin
            statusCode = addiOvf;
        end else begin
            statusCode = addOvf;
        end
    end

    // Becomes addi r30, r0 so the normal write path carries the code
    always_comb begin
        ovfInstr = '0;
        ovfInstr.opcode = opAddi;
        ovfInstr.rd = statusReg;
    end

    always_comb begin
        xmNext.instr = anyOverflow ? ovfInstr : dx.instr;
        xmNext.storeVal = fwdB;
        if (anyOverflow) begin
            xmNext.result = {{(dataWidth-2){1'b0}}, statusCode};
        end else if (opcode == opJal) begin
            xmNext.result = dx.pcPlus1;
        end else begin
            xmNext.result = aluResult;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            xm <= '0;
        end else begin
            xm <= xmNext;
        end
    end

    // A redirect comes from a jump or branch and leaves a bubble in DX
    redirectCheck: assert property (@(posedge clock) disable iff (rst)
        redirectValid |=> (xm.instr.opcode inside {opJ, opJal, opJr, opBne, opBlt})
                          && (dx.instr == '0));

endmodule

// ==== hw/memWriteback.sv ====
module memWriteback import cpuPkg::*; (
    input  logic                 clock,
    input  logic                 rst,
    input  xmT                   xm,
    output logic [dataWidth-1:0] dmemAddr,
    output logic [dataWidth-1:0] dmemWriteData,
    output logic                 dmemWren,
    input  logic [dataWidth-1:0] dmemReadData,
    output wbT                   wb
);

    logic storeHit;
    mwT   mw;

    ////////////////////////////////////////////////////////////
    // Data memory
    ////////////////////////////////////////////////////////////

    assign dmemAddr = xm.result;
    assign dmemWren = xm.instr.opcode == opSw;

    // Store data may still be in flight in MW, e.g. lw then sw
    assign storeHit = wb.en && wb.idx == xm.instr.rd;
    assign dmemWriteData = storeHit ? wb.data : xm.storeVal;

    ////////////////////////////////////////////////////////////
    // MW latch and writeback
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            mw <= '0;
        end else begin
            mw.instr <= xm.instr;
            mw.result <= xm.result;
            mw.loadData <= dmemReadData;
        end
    end

    // Bubble writes r0, so enable stays low out of reset
    assign wb.en = writesReg(mw.instr);
    assign wb.idx = destReg(mw.instr);
    assign wb.data = (mw.instr.opcode == opLw) ? mw.loadData : mw.result;

endmodule

// ==== hw/cpuTop.sv ====
module cpuTop import cpuPkg::*; #(
    parameter int imemAddrWidth = 12
) (
    input  logic                     clock,
    input  logic                     rst,
    output logic [imemAddrWidth-1:0] imemAddr,
    input  logic [dataWidth-1:0]     imemData,
    output logic [dataWidth-1:0]     dmemAddr,
    output logic [dataWidth-1:0]     dmemWriteData,
    output logic                     dmemWren,
    input  logic [dataWidth-1:0]     dmemReadData
);

    instrT                   fdInstr;
    logic [dataWidth-1:0]    fdPcPlus1;
    logic [regAddrWidth-1:0] readIdxA;
    logic [regAddrWidth-1:0] readIdxB;
    logic [dataWidth-1:0]    readDataA;
    logic [dataWidth-1:0]    readDataB;
    logic                    loadUseStall;
    logic                    redirectValid;
    logic [dataWidth-1:0]    redirectPc;
    dxT                      dx;
    xmT                      xm;
    wbT                      wb;

    fetchStage #(.imemAddrWidth(imemAddrWidth)) fetch (
        .clock, .rst, .loadUseStall, .redirectValid, .redirectPc,
        .imemAddr, .imemData, .fdInstr, .fdPcPlus1
    );

    regFile regs (
        .clock, .rst, .readIdxA, .readIdxB, .readDataA, .readDataB, .wb
    );

    decodeStage decode (
        .clock, .rst, .fdInstr, .fdPcPlus1, .readIdxA, .readIdxB,
        .readDataA, .readDataB, .redirectValid, .loadUseStall, .dx
    );

    // XM result is also the data memory address
    executeStage execute (
        .clock, .rst, .dx, .xmForwardData(dmemAddr), .wb,
        .redirectValid, .redirectPc, .xm
    );

    memWriteback memWb (
        .clock, .rst, .xm, .dmemAddr, .dmemWriteData, .dmemWren, .dmemReadData, .wb
    );

endmodule

// ==== sim/cpuTbProgram.svh ====
// Columns of each store entry are address, data, test number, last store of the test
// Instruction fields follow the ISA
// sw and lw take rd and imm(rs), and branches compare rd with rs

task automatic loadProgram();
    // Test 0 is a dependent ALU chain
    imem[0] = encI(opAddi, 1, 0, 5);
    imem[1] = encI(opAddi, 2, 1, 3);
    imem[2] = encR(3, 1, 2, 0, aluAdd);
    imem[3] = encR(4, 3, 1, 0, aluSub);
    imem[4] = encR(5, 4, 3, 0, aluAnd);
    imem[5] = encR(6, 5, 1, 0, aluOr);
    imem[6] = encR(7, 6, 0, 4, aluSll);
    imem[7] = encI(opAddi, 8, 0, -64);
    imem[8] = encR(9, 8, 0, 3, aluSra);
    imem[9] = encI(opSw, 9, 0, 1);
    imem[10] = encI(opSw, 7, 0, 2);
    imem[11] = encI(opSw, 4, 0, 3);
    imem[12] = encI(opSw, 6, 0, 4);
    imem[13] = encI(opAddi, 10, 6, 100);
    imem[14] = encR(11, 10, 5, 0, aluAdd);
    imem[15] = encI(opSw, 11, 0, 5);
    // Test 1 uses a loaded word at once
    imem[16] = encI(opAddi, 12, 0, 40);
    imem[17] = encI(opLw, 13, 12, 0);
    imem[18] = encR(14, 13, 1, 0, aluAdd);
    imem[19] = encI(opSw, 14, 0, 6);
    imem[20] = encI(opLw, 15, 12, 2);
    imem[21] = encI(opSw, 15, 0, 7);
    // Test 2 has poison stores in the branch shadows
    imem[22] = encI(opAddi, 16, 0, 1);
    imem[23] = encI(opBne, 16, 0, 2);
    imem[24] = encI(opSw, 16, 0, 63);
    imem[25] = encI(opSw, 16, 0, 63);
    imem[26] = encI(opBne, 16, 16, 2);
    imem[27] = encI(opSw, 16, 0, 8);
    imem[28] = encI(opBlt, 0, 16, 2);
    imem[29] = encI(opSw, 16, 0, 63);
    imem[30] = encI(opSw, 16, 0, 63);
    imem[31] = encI(opSw, 1, 0, 9);
    // Test 3 calls with jal and returns with jr through r31
    imem[32] = encJ(opJal, 37);
    // jr lands here and stores the link value
    imem[33] = encI(opSw, 31, 0, 10);
    imem[34] = encJ(opJ, 43);
    imem[35] = encI(opSw, 16, 0, 63);
    imem[36] = encI(opSw, 16, 0, 63);
    // Called routine returns through r31
    imem[37] = encI(opAddi, 17, 0, 43);
    imem[38] = encI(opJr, 31, 0, 0);
    imem[39] = encI(opSw, 16, 0, 63);
    imem[40] = encI(opSw, 16, 0, 63);
    imem[41] = encI(opSw, 16, 0, 63);
    imem[42] = encI(opSw, 16, 0, 63);
    imem[43] = encI(opSw, 17, 0, 11);
    // Test 4 overflows an add into r30
    imem[44] = encI(opAddi, 18, 0, 1);
    imem[45] = encR(19, 18, 0, 30, aluSll);
    imem[46] = encI(opAddi, 20, 19, -1);
    imem[47] = encR(21, 19, 20, 0, aluAdd);
    imem[48] = encI(opAddi, 22, 0, 77);
    imem[49] = encR(22, 21, 18, 0, aluAdd);
    imem[50] = encI(opSw, 22, 0, 12);
    imem[51] = encI(opSw, 30, 0, 13);

    // Expected stores as worked out by hand
    addStore(1, 32'hffff_fff8, 0, 0);
    addStore(2, 208, 0, 0);
    addStore(3, 8, 0, 0);
    addStore(4, 13, 0, 0);
    addStore(5, 121, 0, 1);
    addStore(6, 4301, 1, 0);
    addStore(7, 4306, 1, 1);
    addStore(8, 1, 2, 0);
    addStore(9, 5, 2, 1);
    addStore(10, 33, 3, 0);
    addStore(11, 43, 3, 1);
    addStore(12, 77, 4, 0);
    addStore(13, 1, 4, 1);
endtask

// ==== sim/cpuTb.sv ====
module cpuTb import cpuPkg::*; ();

    localparam int cycleLimit = 400;
    localparam int maxStores = 16;
    localparam logic [31:0] poisonAddr = 32'd63;

    logic        clock;
    logic        rst;
    logic [11:0] imemAddr;
    logic [31:0] imemData;
    logic [31:0] dmemAddr;
    logic [31:0] dmemWriteData;
    logic        dmemWren;
    logic [31:0] dmemReadData;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];

    // Expected store list
    logic [31:0] expAddr [0:maxStores-1];
    logic [31:0] expData [0:maxStores-1];
    int          expTest [0:maxStores-1];
    logic        expLast [0:maxStores-1];
    int          numStores = 0;

    int    storeIdx = 0;
    int    cycles = 0;
    int    errors = 0;
    int    errorsAtTestStart = 0;
    int    testsPassed = 0;
    int    testsFailed = 0;
    logic  reportValid = 1'b0;
    int    reportTest = 0;
    string testNames [0:4] = '{"alu chain", "load use", "branches", "jumps", "overflow"};

    cpuTop #(.imemAddrWidth(12)) i_dut (
        .clock, .rst, .imemAddr, .imemData, .dmemAddr, .dmemWriteData, .dmemWren,
        .dmemReadData
    );

    ////////////////////////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] encR(int rd, int rs, int rt, int shamt, aluOpE op);
        return {5'd0, 5'(rd), 5'(rs), 5'(rt), 5'(shamt), op, 2'b00};
    endfunction

    function automatic logic [31:0] encI(opcodeE op, int rd, int rs, int imm);
        logic [31:0] immBits;
        immBits = imm;
        return {op, 5'(rd), 5'(rs), immBits[16:0]};
    endfunction

    function automatic logic [31:0] encJ(opcodeE op, int target);
        return {op, 27'(target)};
    endfunction

    task automatic addStore(int addr, logic [31:0] data, int test, logic last);
        expAddr[numStores] = addr;
        expData[numStores] = data;
        expTest[numStores] = test;
        expLast[numStores] = last;
        numStores++;
    endtask

    `include "cpuTbProgram.svh"

    ////////////////////////////////////////////////////////////
    // Clock and memory models
    ////////////////////////////////////////////////////////////

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Both memories answer in the same cycle
    assign imemData = (imemAddr < 12'd64) ? imem[imemAddr[5:0]] : 32'd0;
    assign dmemReadData = dmem[dmemAddr[5:0]];

    always @(posedge clock) begin
        if (dmemWren) begin
            dmem[dmemAddr[5:0]] <= dmemWriteData;
        end
    end

    always @(posedge clock) begin
        if (!rst) begin
            cycles <= cycles + 1;
        end
        reportValid <= 1'b0;
        if (!rst && dmemWren && storeIdx < numStores) begin
            storeIdx <= storeIdx + 1;
            reportValid <= expLast[storeIdx];
            reportTest <= expTest[storeIdx];
        end
    end

    // Report on the falling edge, after the store checks have fired
    always @(negedge clock) begin
        if (reportValid) begin
            if (errors == errorsAtTestStart) begin
                testsPassed++;
                $display("test %0d %s passed", reportTest, testNames[reportTest]);
            end else begin
                testsFailed++;
                $display("test %0d %s failed with %0d errors", reportTest,
                         testNames[reportTest], errors - errorsAtTestStart);
            end
            errorsAtTestStart = errors;
        end
    end

    ////////////////////////////////////////////////////////////
    // Store checks
    ////////////////////////////////////////////////////////////

    quietInReset: assert property (@(posedge clock) rst |-> !dmemWren)
        else begin
            errors++;
            $display("store strobe was high during reset at time %0t", $time);
        end

    noPoisonStore: assert property (@(posedge clock) dmemWren |-> dmemAddr != poisonAddr)
        else begin
            errors++;
            $display("a squashed store reached memory at time %0t", $time);
        end

    noExtraStore: assert property (@(posedge clock) dmemWren |-> storeIdx < numStores)
        else begin
            errors++;
            $display("more stores than expected at time %0t", $time);
        end

    // Messages use the values the check itself sampled
    storeAddrCheck: assert property (@(posedge clock) disable iff (rst)
        (dmemWren && storeIdx < numStores) |-> dmemAddr == expAddr[storeIdx])
        else begin
            errors++;
            $display("FAILED time %0t dmemAddr got %0h expected %0h", $time,
                     $sampled(dmemAddr), expAddr[$sampled(storeIdx)]);
        end

    storeDataCheck: assert property (@(posedge clock) disable iff (rst)
        (dmemWren && storeIdx < numStores) |-> dmemWriteData == expData[storeIdx])
        else begin
            errors++;
            $display("FAILED time %0t dmemWriteData got %0h expected %0h", $time,
                     $sampled(dmemWriteData), expData[$sampled(storeIdx)]);
        end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst = 1'b1;
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'd0;
            // Fill depends on the full word address
            dmem[i] = 32'h1000 + 32'(i) * 5;
        end
        loadProgram();
        repeat (4) @(negedge clock);
        rst = 1'b0;
        while (storeIdx < numStores && cycles < cycleLimit) begin
            @(negedge clock);
        end
        // Let the last report and any late store land
        repeat (2) @(negedge clock);
        if (storeIdx < numStores) begin
            errors++;
            $display("timed out after %0d cycles with %0d of %0d stores seen", cycles,
                     storeIdx, numStores);
        end
        $display("tests passed %0d failed %0d, errors %0d", testsPassed, testsFailed, errors);
        if (errors == 0 && testsPassed == 5) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+sim
hw/cpuPkg.sv
hw/fetchStage.sv
hw/regFile.sv
hw/decodeStage.sv
hw/aluUnit.sv
hw/executeStage.sv
hw/memWriteback.sv
hw/cpuTop.sv
sim/cpuTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --assert -Wno-fatal -j 0
TOP = cpuTb
FILELIST = src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
